// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_mul_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
common/mul_pkg.sv
multiplier/booth_multiplier.sv
logic/issue_ctrl.sv
logic/reg_file.sv
logic/writeback.sv
logic/mul_unit_top.sv
sim/tb_mul_unit.sv

// ==== common/mul_pkg.sv ====
// Multiply path shared types

package mul_pkg;

   // ------------------------------------------------------------------------
   // Widths with a meaning
   // ------------------------------------------------------------------------

   // Data word and multiply operand
   typedef logic [15:0] word_t;

   // Register file index
   typedef logic [2:0] reg_idx_t;

   // Register count, fixed by the 3-bit index
   localparam int NUM_REGS = 8;

   // ------------------------------------------------------------------------
   // Instruction format
   // ------------------------------------------------------------------------

   // Instruction kinds
   typedef enum logic [1:0] {
      OP_NOP = 2'd0,
      OP_LDI = 2'd1,
      OP_MUL = 2'd2
   } op_e;

   // Packed instruction, 28 bits
   // Top bit is reserved and ignored by decode
   typedef struct packed {
      logic     rsvd;
      op_e      op;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    imm;
   } instr_t;

   // ------------------------------------------------------------------------
   // Internal records
   // ------------------------------------------------------------------------

   // Multiply request with destination tag
   typedef struct packed {
      reg_idx_t rd;
      word_t    multiplicand;
      word_t    multiplier;
   } mul_req_t;

   // Writeback record
   typedef struct packed {
      reg_idx_t rd;
      word_t    data;
   } wb_t;

   // Multiplier control
   typedef enum logic {
      MUL_IDLE = 1'b0,
      MUL_RUN  = 1'b1
   } mul_state_e;

   // Issue control
   typedef enum logic {
      ISS_READY = 1'b0,
      ISS_WAIT  = 1'b1
   } iss_state_e;

endpackage

// ==== logic/issue_ctrl.sv ====
// Instruction issue and stall control
`timescale 1ns/1ps

module issue_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              instr_valid,
   input  mul_pkg::instr_t   instr,
   input  mul_pkg::word_t    rd_data_a,
   input  mul_pkg::word_t    rd_data_b,
   input  logic              mul_done,
   output logic              instr_ready,
   output mul_pkg::reg_idx_t rd_addr_a,
   output mul_pkg::reg_idx_t rd_addr_b,
   output logic              mul_start,
   output mul_pkg::mul_req_t mul_req,
   output logic              ldi_valid,
   output mul_pkg::wb_t      ldi_wb
);
   import mul_pkg::*;

   iss_state_e state;
   iss_state_e state_nxt;
   logic       accept;
   logic       accept_mul;
   logic       accept_ldi;

   // ------------------------------------------------------------------------
   // Decode
   // ------------------------------------------------------------------------

   assign instr_ready = (state == ISS_READY);
   assign accept      = instr_valid && instr_ready;
   assign accept_mul  = accept && (instr.op == OP_MUL);
   // No-ops are accepted and dropped here
   assign accept_ldi  = accept && (instr.op == OP_LDI);

   // Operand read straight from the instruction
   assign rd_addr_a = instr.rs;
   assign rd_addr_b = instr.rt;

   // Multiplier captures at the accepting edge
   assign mul_start = accept_mul;
   assign mul_req   = '{rd: instr.rd, multiplicand: rd_data_a, multiplier: rd_data_b};

   // ------------------------------------------------------------------------
   // Stall FSM
   // ------------------------------------------------------------------------

   always_comb
   begin
      state_nxt = state;
      case (state)
         ISS_READY:
         begin
            if (accept_mul)
               state_nxt = ISS_WAIT;
         end
         ISS_WAIT:
         begin
            // Result is written at the same edge
            if (mul_done)
               state_nxt = ISS_READY;
         end
         default:
         begin
            state_nxt = ISS_READY;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= ISS_READY;
      else
         state <= state_nxt;
   end

   // ------------------------------------------------------------------------
   // Load-immediate record
   // ------------------------------------------------------------------------

   // Pulse in the cycle after acceptance
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ldi_valid <= 1'b0;
      else
         ldi_valid <= accept_ldi;
   end

   always_ff @(posedge clk)
   begin
      if (accept_ldi)
         ldi_wb <= '{rd: instr.rd, data: instr.imm};
   end

endmodule

// ==== logic/mul_unit_top.sv ====
// Multiply path top level
`timescale 1ns/1ps

module mul_unit_top (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            instr_valid,
   input  mul_pkg::instr_t instr,
   output logic            instr_ready,
   output logic            wb_valid,
   output mul_pkg::wb_t    wb
);
   import mul_pkg::*;

   // ------------------------------------------------------------------------
   // Internal nets
   // ------------------------------------------------------------------------

   // Operand read
   reg_idx_t rd_addr_a;
   reg_idx_t rd_addr_b;
   word_t    rd_data_a;
   word_t    rd_data_b;

   // Multiplier hand-off
   logic     mul_start;
   mul_req_t mul_req;
   logic     mul_done;
   wb_t      mul_result;

   // Load-immediate hand-off
   logic     ldi_valid;
   wb_t      ldi_wb;

   // Register file write
   logic     we;
   reg_idx_t wr_addr;
   word_t    wr_data;

   // ------------------------------------------------------------------------
   // Blocks
   // ------------------------------------------------------------------------

   issue_ctrl u_issue_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_data_a   (rd_data_a),
      .rd_data_b   (rd_data_b),
      .mul_done    (mul_done),
      .instr_ready (instr_ready),
      .rd_addr_a   (rd_addr_a),
      .rd_addr_b   (rd_addr_b),
      .mul_start   (mul_start),
      .mul_req     (mul_req),
      .ldi_valid   (ldi_valid),
      .ldi_wb      (ldi_wb)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .we        (we),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

   booth_multiplier u_booth_multiplier (
      .clk        (clk),
      .rst_n      (rst_n),
      .mul_start  (mul_start),
      .mul_req    (mul_req),
      .mul_done   (mul_done),
      .mul_result (mul_result)
   );

   writeback u_writeback (
      .clk        (clk),
      .rst_n      (rst_n),
      .ldi_valid  (ldi_valid),
      .ldi_wb     (ldi_wb),
      .mul_done   (mul_done),
      .mul_result (mul_result),
      .we         (we),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wb_valid   (wb_valid),
      .wb         (wb)
   );

endmodule

// ==== logic/reg_file.sv ====
// Register file, two reads, one write
`timescale 1ns/1ps

module reg_file (
   input  logic              clk,
   input  logic              rst_n,
   input  mul_pkg::reg_idx_t rd_addr_a,
   input  mul_pkg::reg_idx_t rd_addr_b,
   input  logic              we,
   input  mul_pkg::reg_idx_t wr_addr,
   input  mul_pkg::word_t    wr_data,
   output mul_pkg::word_t    rd_data_a,
   output mul_pkg::word_t    rd_data_b
);
   import mul_pkg::*;

   word_t regs [NUM_REGS];

   // Single write port
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end
      else if (we)
      begin
         regs[wr_addr] <= wr_data;
      end
   end

   // Write-through reads
   // A load-immediate writes at the edge where the next instruction
   // captures its operands, so the pending write is passed through
   always_comb
   begin
      if (we && (wr_addr == rd_addr_a))
         rd_data_a = wr_data;
      else
         rd_data_a = regs[rd_addr_a];
      if (we && (wr_addr == rd_addr_b))
         rd_data_b = wr_data;
      else
         rd_data_b = regs[rd_addr_b];
   end

endmodule

// ==== logic/writeback.sv ====
// Result writeback and report
`timescale 1ns/1ps

module writeback (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ldi_valid,
   input  mul_pkg::wb_t      ldi_wb,
   input  logic              mul_done,
   input  mul_pkg::wb_t      mul_result,
   output logic              we,
   output mul_pkg::reg_idx_t wr_addr,
   output mul_pkg::word_t    wr_data,
   output logic              wb_valid,
   output mul_pkg::wb_t      wb
);
   import mul_pkg::*;

   wb_t wb_sel;

   // ------------------------------------------------------------------------
   // Source select
   // ------------------------------------------------------------------------

   // Issue stall keeps the two sources apart
   always_comb
   begin
      if (ldi_valid)
         wb_sel = ldi_wb;
      else
         wb_sel = mul_result;
   end

   // Register file write lands on the next edge
   assign we      = ldi_valid || mul_done;
   assign wr_addr = wb_sel.rd;
   assign wr_data = wb_sel.data;

   // ------------------------------------------------------------------------
   // Reported result
   // ------------------------------------------------------------------------

   // Same edge as the register file write
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wb_valid <= 1'b0;
      else
         wb_valid <= we;
   end

   // Record holds between writebacks
   always_ff @(posedge clk)
   begin
      if (we)
         wb <= wb_sel;
   end

endmodule

// ==== multiplier/booth_multiplier.sv ====
// Radix-4 Booth multiplier
`timescale 1ns/1ps

module booth_multiplier (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              mul_start,
   input  mul_pkg::mul_req_t mul_req,
   output logic              mul_done,
   output mul_pkg::wb_t      mul_result
);
   import mul_pkg::*;

   mul_state_e  state;
   mul_state_e  state_nxt;
   logic [3:0]  step_cnt;
   logic        cnt_clr;
   logic        cnt_en;
   logic        load;
   logic        step_en;
   // {upper half, multiplier bits, guard bit}
   logic [32:0] product;
   word_t       mcand;
   word_t       mcand_x2;
   word_t       upper_sum;
   reg_idx_t    rd_tag;

   // ------------------------------------------------------------------------
   // Control FSM
   // ------------------------------------------------------------------------

   // Counter top bit marks the end of the eighth step
   assign mul_done = step_cnt[3];

   always_comb
   begin
      state_nxt = state;
      cnt_clr   = 1'b0;
      cnt_en    = 1'b0;
      case (state)
         MUL_IDLE:
         begin
            if (mul_start)
            begin
               state_nxt = MUL_RUN;
               cnt_clr   = 1'b1;
            end
         end
         MUL_RUN:
         begin
            // Done cycle clears the counter on the way out
            if (mul_done)
            begin
               state_nxt = MUL_IDLE;
               cnt_clr   = 1'b1;
            end
            else
            begin
               cnt_en = 1'b1;
            end
         end
         default:
         begin
            state_nxt = MUL_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= MUL_IDLE;
      else
         state <= state_nxt;
   end

   // Step counter
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         step_cnt <= 4'h0;
      else if (cnt_clr)
         step_cnt <= 4'h0;
      else if (cnt_en)
         step_cnt <= step_cnt + 4'h1;
   end

   // ------------------------------------------------------------------------
   // Booth datapath
   // ------------------------------------------------------------------------

   assign load    = (state == MUL_IDLE) && mul_start;
   assign step_en = (state == MUL_RUN) && !mul_done;

   // Recode the low three product bits into one of five actions
   always_comb
   begin
      case (product[2:0])
         3'b001,
         3'b010:  upper_sum = product[32:17] + mcand;
         3'b011:  upper_sum = product[32:17] + mcand_x2;
         3'b100:  upper_sum = product[32:17] - mcand_x2;
         3'b101,
         3'b110:  upper_sum = product[32:17] - mcand;
         // 000 and 111 add zero
         default: upper_sum = product[32:17];
      endcase
   end

   // Operand capture, then add and arithmetic shift by two
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         product  <= {16'h0000, mul_req.multiplier, 1'b0};
         mcand    <= mul_req.multiplicand;
         mcand_x2 <= {mul_req.multiplicand[14:0], 1'b0};
         rd_tag   <= mul_req.rd;
      end
      else if (step_en)
      begin
         product <= {upper_sum[15], upper_sum[15], upper_sum, product[16:2]};
      end
   end

   // Low half of the signed product, skipping the guard bit
   assign mul_result = '{rd: rd_tag, data: product[16:1]};

endmodule

// ==== sim/mul_patterns.txt ====
// Columns: op/rd/rs/rt (3 hex), imm (4 hex), expected wb index (1 hex), wb data (4 hex)
// No-op lines carry zeros, the all-F record ends the list
// Loads for the corner operands
240_0001_1_0001
280_FFFF_2_FFFF
2C0_8000_3_8000
300_7FFF_4_7FFF
000_0000_0_0000
340_0123_5_0123
380_FFFD_6_FFFD
3C0_1234_7_1234
// r0 = r7 * r0, times zero
438_0000_0_0000
// Times one, times minus one
439_0000_0_1234
43A_0000_0_EDCC
// 0x8000 times minus one wraps
41A_0000_0_8000
// 0x7FFF squared
424_0000_0_0001
// Mixed and equal signs
42E_0000_0_FC97
436_0000_0_0009
412_0000_0_0001
41B_0000_0_0000
43E_0000_0_C964
// Chain through the previous multiply
466_0000_1_8003
48E_0000_2_7FF7
// Multiply right behind the load it reads
2C0_0005_3_0005
51B_0000_4_0019
340_FFFE_5_FFFE
5A5_0000_6_FFCE
5F2_0000_7_01C2
000_0000_0_0000
// Same register loaded twice in a row
200_ABCD_0_ABCD
200_0003_0_0003
447_0000_1_0546
FFF_FFFF_F_FFFF

// ==== sim/tb_mul_unit.sv ====
// Multiply path testbench
`timescale 1ns/1ps

module tb_mul_unit;
   import mul_pkg::*;

   // One expected writeback and the edge it must land on
   typedef struct packed {
      reg_idx_t    idx;
      word_t       data;
      logic [31:0] due;
   } exp_t;

   localparam int PAT_DEPTH  = 64;
   localparam int WAIT_LIMIT = 20;
   localparam int RAND_COUNT = 200;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        instr_valid;
   instr_t      instr;
   logic        instr_ready;
   logic        wb_valid;
   wb_t         wb;

   // {instr, pad + index, data} per record
   logic [47:0] pat_mem [PAT_DEPTH];
   word_t       model [NUM_REGS];
   exp_t        exp_q [$];
   // Edge count since reset release
   logic [31:0] cycle;
   // First edge where issue may accept again
   logic [31:0] ready_edge;
   logic        drive_done;
   integer      seed;

   mul_unit_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .wb_valid    (wb_valid),
      .wb          (wb)
   );

   always #20 clk = ~clk;

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cycle <= '0;
      else
         cycle <= cycle + 32'd1;
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   // Sampled at the falling edge, wb is stable there
   task automatic wait_wb_valid(input string what);
      int tmo;
      tmo = 0;
      while (!wb_valid)
      begin
         @(negedge clk);
         tmo++;
         if (tmo > WAIT_LIMIT)
         begin
            $display("Timeout at %0t: wb_valid never rose during %s", $time, what);
            stop_on_error();
         end
      end
   endtask

   task automatic check_wb_idx(input reg_idx_t exp, input string what);
      wait_wb_valid(what);
      if (wb.rd !== exp)
      begin
         $display("mismatch at %0t: %s got %0d expected %0d", $time, what, wb.rd, exp);
         stop_on_error();
      end
   endtask

   task automatic check_wb_data(input word_t exp, input string what);
      wait_wb_valid(what);
      if (wb.data !== exp)
      begin
         $display("mismatch at %0t: %s got %h expected %h", $time, what, wb.data, exp);
         stop_on_error();
      end
   endtask

   task automatic check_ready(input logic exp, input string what);
      if (instr_ready !== exp)
      begin
         $display("mismatch at %0t: instr_ready for %s got %b expected %b",
                  $time, what, instr_ready, exp);
         stop_on_error();
      end
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------

   // Called at a falling edge, returns one falling edge after acceptance
   task automatic issue_instr(input instr_t ins, input reg_idx_t exp_idx,
                              input word_t exp_data, input string what);
      int          tmo;
      exp_t        e;
      logic [31:0] acc_edge;
      instr_valid = 1'b1;
      instr       = ins;
      tmo         = 0;
      // Ready must follow the stall window of the last multiply
      check_ready((cycle + 32'd1) >= ready_edge, what);
      while (!instr_ready)
      begin
         @(negedge clk);
         tmo++;
         if (tmo > WAIT_LIMIT)
         begin
            $display("Timeout at %0t: instr_ready stayed low for %s", $time, what);
            stop_on_error();
         end
         check_ready((cycle + 32'd1) >= ready_edge, what);
      end
      acc_edge = cycle + 32'd1;
      e.idx    = exp_idx;
      e.data   = exp_data;
      if (ins.op == OP_LDI)
      begin
         e.due = acc_edge + 32'd1;
         exp_q.push_back(e);
         model[exp_idx] = exp_data;
      end
      else if (ins.op == OP_MUL)
      begin
         // Eight steps, a done cycle, then the write edge
         e.due      = acc_edge + 32'd9;
         ready_edge = acc_edge + 32'd10;
         exp_q.push_back(e);
         model[exp_idx] = exp_data;
      end
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   task automatic run_patterns();
      int     i;
      instr_t ins;
      i = 0;
      // All-ones record ends the list
      while ((i < PAT_DEPTH) && (pat_mem[i] != 48'hFFFF_FFFF_FFFF))
      begin
         ins = instr_t'(pat_mem[i][47:20]);
         issue_instr(ins, pat_mem[i][18:16], pat_mem[i][15:0],
                     $sformatf("pattern %0d", i));
         i++;
      end
      if ((i == 0) || (i == PAT_DEPTH))
      begin
         $display("Pattern file is empty or has no end record");
         stop_on_error();
      end
   endtask

   task automatic run_random();
      logic [31:0] r;
      logic [1:0]  gap;
      instr_t      ins;
      word_t       exp_data;
      for (int k = 0; k < RAND_COUNT; k++)
      begin
         r        = $random(seed);
         ins.rsvd = 1'b0;
         ins.rd   = r[2:0];
         ins.rs   = r[5:3];
         ins.rt   = r[8:6];
         // Mostly multiplies, some loads, few no-ops
         case (r[11:9])
            3'd0:                ins.op = OP_NOP;
            3'd1, 3'd2, 3'd3:    ins.op = OP_LDI;
            default:             ins.op = OP_MUL;
         endcase
         gap     = r[13:12];
         r       = $random(seed);
         ins.imm = r[15:0];
         // Low 16 bits of the signed product
         if (ins.op == OP_MUL)
            exp_data = model[ins.rs] * model[ins.rt];
         else
            exp_data = ins.imm;
         issue_instr(ins, ins.rd, exp_data, $sformatf("random %0d", k));
         repeat (gap) @(negedge clk);
      end
   endtask

   // ------------------------------------------------------------------------
   // Writeback monitor
   // ------------------------------------------------------------------------

   task automatic watch_writebacks();
      exp_t e;
      int   idle;
      idle = 0;
      while (!drive_done || (exp_q.size() != 0))
      begin
         if (exp_q.size() != 0)
         begin
            e    = exp_q.pop_front();
            idle = 0;
            check_wb_idx(e.idx, "writeback index");
            if (cycle != e.due)
            begin
               $display("Writeback came at edge %0d instead of edge %0d (time %0t)",
                        cycle, e.due, $time);
               stop_on_error();
            end
            check_wb_data(e.data, "writeback data");
         end
         else
         begin
            if (wb_valid)
            begin
               $display("Unexpected writeback at %0t with nothing pending", $time);
               stop_on_error();
            end
            idle++;
            if (idle > 4 * WAIT_LIMIT)
            begin
               $display("Timeout at %0t: driver went quiet without finishing", $time);
               stop_on_error();
            end
         end
         @(negedge clk);
      end
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------

   initial
   begin
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      ready_edge  = '0;
      drive_done  = 1'b0;
      seed        = 32'hac4f1d09;
      for (int i = 0; i < NUM_REGS; i++)
         model[i] = '0;
      $readmemh("sim/mul_patterns.txt", pat_mem);

      // Two cycles of reset, released on a falling edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_ready(1'b1, "idle after reset");

      fork
         begin
            // Quiet period, monitor flags any writeback
            repeat (4) @(negedge clk);
            run_patterns();
            run_random();
            drive_done = 1'b1;
         end
         watch_writebacks();
      join

      repeat (5)
      begin
         @(negedge clk);
         if (wb_valid)
         begin
            $display("Unexpected writeback after the last instruction at %0t", $time);
            stop_on_error();
         end
      end
      $display("Test passed");
      $finish;
   end

endmodule
